/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_execute
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported failure"; exit 1; fi

check: run
	@grep -q '>>> PASS' $(LOG) || { echo "No pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* branch_unit.sv */
/* Branch unit of the execute stage: resolves conditional branches and jumps,
 * computes target and link, and flags register write-back for JAL/JALR.
 */
`timescale 1ns/100ps

module branch_unit
    import rv_isa_pkg::*, rv_data_pkg::*;
(
    xu_issue_if.unit iss,         // Operands, PC and gated operation
    output word_t    link_o,      // Return address for JAL/JALR
    output word_t    target_o,    // Redirect address
    output logic     jump_o,      // Redirect taken
    output logic     we_rf_o      // Link goes to the register file
);

    word_t pc_rel;     // PC plus offset
    word_t reg_rel;    // Base plus offset for JALR
    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  taken;      // Condition outcome of a conditional branch

    assign pc_rel  = iss.pc + iss.op_c;
    assign reg_rel = iss.op_a + iss.op_c;
    assign eq      = iss.op_a == iss.op_b;
    assign lt_s    = $signed(iss.op_a) < $signed(iss.op_b);
    assign lt_u    = iss.op_a < iss.op_b;

    always_comb begin
        case (iss.op)
            BEQ:     taken = eq;
            BNE:     taken = !eq;
            BLT:     taken = lt_s;
            BGE:     taken = !lt_s;
            BLTU:    taken = lt_u;
            BGEU:    taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Target, link and flags
    ////////////////////////////////////////
    always_comb begin
        link_o   = '0;                                   // No link for branches
        target_o = '0;
        jump_o   = 1'b0;
        we_rf_o  = 1'b0;
        case (iss.op)
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                target_o = pc_rel;
                jump_o   = taken;
            end
            JAL: begin
                target_o = pc_rel;
                link_o   = iss.pc + word_t'(PC_STEP);
                jump_o   = 1'b1;
                we_rf_o  = 1'b1;
            end
            JALR: begin
                target_o = {reg_rel[XLEN-1:1], 1'b0};    // Bit 0 cleared per spec
                link_o   = iss.pc + word_t'(PC_STEP);
                jump_o   = 1'b1;
                we_rf_o  = 1'b1;
            end
            default: ;                                   // NOP and foreign ops
        endcase
    end

endmodule

/* compile.f */
rv_data_pkg.sv
rv_isa_pkg.sv
xu_issue_if.sv
int_alu_unit.sv
branch_unit.sv
load_store_unit.sv
execute.sv
tb_execute.sv

/* execute.sv */
/* Execute stage top level: dispatches the operation to the ALU, branch or
 * load/store unit, and registers the selected results for the next stage.
 */
`timescale 1ns/100ps

module execute
    import rv_isa_pkg::*, rv_data_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  word_t    pc_i,          // PC of the instruction
    input  word_t    op_a_i,        // Operands from operand fetch
    input  word_t    op_b_i,
    input  word_t    op_c_i,
    input  op_t      op_i,          // Operation
    input  xu_t      xu_sel_i,      // Execution-unit selector
    input  tag_t     tag_i,         // Instruction tag
    output word_t    result0_o,     // Data result
    output word_t    result1_o,     // Target or address
    output logic     jump_o,        // Branch taken
    output logic     we_rf_o,       // Register-file write enable
    output logic     ls_op_o,       // Memory operation retiring
    output logic     read_o,        // Same-cycle read request
    output word_t    read_addr_o,
    output byte_en_t we_mem_o,      // Store byte enables
    output tag_t     tag_o,
    output op_t      op_o
);

    xu_issue_if alu_if ();
    xu_issue_if br_if ();
    xu_issue_if lsu_if ();

    word_t    alu_result;
    word_t    br_link;
    word_t    br_target;
    logic     br_jump;
    logic     br_we;
    word_t    lsu_addr;
    word_t    lsu_data;
    byte_en_t lsu_be;
    logic     lsu_we;

    word_t    result0_d;   // Demux outputs, next register values
    word_t    result1_d;
    logic     jump_d;
    logic     we_rf_d;
    logic     ls_op_d;
    byte_en_t we_mem_d;

    ////////////////////////////////////////
    // Dispatcher
    ////////////////////////////////////////
    assign alu_if.op_a = op_a_i;          // Operands fan out unchanged
    assign alu_if.op_b = op_b_i;
    assign alu_if.op_c = op_c_i;
    assign alu_if.pc   = pc_i;
    assign alu_if.op   = (xu_sel_i inside {XU_ADDER, XU_LOGIC, XU_SHIFT}) ? op_i : NOP;

    assign br_if.op_a  = op_a_i;
    assign br_if.op_b  = op_b_i;
    assign br_if.op_c  = op_c_i;
    assign br_if.pc    = pc_i;
    assign br_if.op    = (xu_sel_i == XU_BRANCH) ? op_i : NOP;

    assign lsu_if.op_a = op_a_i;
    assign lsu_if.op_b = op_b_i;
    assign lsu_if.op_c = op_c_i;
    assign lsu_if.pc   = pc_i;
    assign lsu_if.op   = (xu_sel_i == XU_MEMORY) ? op_i : NOP;

    int_alu_unit u_alu (
        .iss      (alu_if.unit),
        .result_o (alu_result)
    );

    branch_unit u_branch (
        .iss      (br_if.unit),
        .link_o   (br_link),
        .target_o (br_target),
        .jump_o   (br_jump),
        .we_rf_o  (br_we)
    );

    load_store_unit u_lsu (
        .iss          (lsu_if.unit),
        .addr_o       (lsu_addr),
        .store_data_o (lsu_data),
        .byte_en_o    (lsu_be),
        .we_rf_o      (lsu_we),
        .read_o       (read_o),        // Read request leaves unregistered
        .read_addr_o  (read_addr_o)
    );

    ////////////////////////////////////////
    // Result demux
    ////////////////////////////////////////
    always_comb begin
        result0_d = op_b_i;               // Bypass by default
        result1_d = '0;
        jump_d    = 1'b0;
        we_rf_d   = 1'b1;
        ls_op_d   = 1'b0;
        we_mem_d  = '0;
        case (xu_sel_i)
            XU_ADDER, XU_LOGIC, XU_SHIFT: result0_d = alu_result;
            XU_BRANCH: begin
                result0_d = br_link;
                result1_d = br_target;
                jump_d    = br_jump;
                we_rf_d   = br_we;
            end
            XU_MEMORY: begin
                result0_d = lsu_data;     // Zero for loads
                result1_d = lsu_addr;
                we_rf_d   = lsu_we;
                ls_op_d   = 1'b1;
                we_mem_d  = lsu_be;
            end
            default: ;                    // XU_BYPASS
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result0_o <= '0;
            result1_o <= '0;
            jump_o    <= 1'b0;
            we_rf_o   <= 1'b0;
            ls_op_o   <= 1'b0;
            we_mem_o  <= '0;
            tag_o     <= '0;
            op_o      <= NOP;
        end else begin
            result0_o <= result0_d;
            result1_o <= result1_d;
            jump_o    <= jump_d;
            we_rf_o   <= we_rf_d;
            ls_op_o   <= ls_op_d;
            we_mem_o  <= we_mem_d;
            tag_o     <= tag_i;           // Tag and op travel with the result
            op_o      <= op_i;
        end
    end

    // Decode must always select a unit
    a_sel_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        !$isunknown(xu_sel_i));

    // A registered jump belongs to a registered flow-control op
    a_jump_op: assert property (@(posedge clk) disable iff (!arst_n_i)
        jump_o |-> is_flow_op(op_o));

endmodule

/* int_alu_unit.sv */
/* Integer ALU of the execute stage: add, subtract, compares, logic and shifts.
 * Purely combinational, fed by the dispatcher through xu_issue_if.
 */
`timescale 1ns/100ps

module int_alu_unit
    import rv_isa_pkg::*, rv_data_pkg::*;
(
    xu_issue_if.unit iss,        // Operands and gated operation
    output word_t    result_o    // Result word for the demux
);

    shamt_t shamt;     // Only the low bits of op_b count
    logic   lt_s;      // Signed less-than
    logic   lt_u;      // Unsigned less-than
    word_t  sum;       // Shared adder output
    word_t  diff;

    assign shamt = iss.op_b[SHAMT_W-1:0];    // Amounts above 31 wrap
    assign lt_s  = $signed(iss.op_a) < $signed(iss.op_b);
    assign lt_u  = iss.op_a < iss.op_b;
    assign sum   = iss.op_a + iss.op_b;
    assign diff  = iss.op_a - iss.op_b;

    ////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////
    always_comb begin
        case (iss.op)
            ADD:     result_o = sum;
            SUB:     result_o = diff;
            SLT:     result_o = word_t'(lt_s);                    // Zero-extended flag
            SLTU:    result_o = word_t'(lt_u);
            AND:     result_o = iss.op_a & iss.op_b;
            OR:      result_o = iss.op_a | iss.op_b;
            XOR:     result_o = iss.op_a ^ iss.op_b;
            SLL:     result_o = iss.op_a << shamt;
            SRL:     result_o = iss.op_a >> shamt;              // Zero fill
            SRA:     result_o = word_t'($signed(iss.op_a) >>> shamt);  // Sign fill
            default: result_o = '0;                             // NOP and foreign ops
        endcase
    end

endmodule

/* load_store_unit.sv */
/* Load/store unit of the execute stage: effective address, memory read
 * request, store lane replication and byte enables. Combinational.
 */
`timescale 1ns/100ps

module load_store_unit
    import rv_isa_pkg::*, rv_data_pkg::*;
(
    xu_issue_if.unit iss,            // Base, offset, store data and gated op
    output word_t    addr_o,         // Effective address
    output word_t    store_data_o,   // Lane-replicated store data
    output byte_en_t byte_en_o,      // Store byte enables
    output logic     we_rf_o,        // Load result goes to the register file
    output logic     read_o,         // Memory read strobe
    output word_t    read_addr_o     // Word-aligned read address
);

    word_t addr;
    logic  is_load;
    logic  is_half;    // Halfword access, needs bit 0 clear
    logic  is_word;    // Word access, needs both low bits clear

    assign addr    = iss.op_a + iss.op_b;
    assign is_load = iss.op inside {LB, LBU, LH, LHU, LW};
    assign is_half = iss.op inside {LH, LHU, SH};
    assign is_word = iss.op inside {LW, SW};

    assign addr_o      = addr;
    assign read_o      = is_load;
    assign read_addr_o = is_load ? {addr[XLEN-1:2], 2'b00} : '0;  // Zero when idle
    assign we_rf_o     = is_load;

    ////////////////////////////////////////
    // Store lanes
    ////////////////////////////////////////
    always_comb begin
        store_data_o = '0;                               // Loads carry no data
        byte_en_o    = '0;
        case (iss.op)
            SB: begin
                store_data_o = {BE_W{iss.op_c[7:0]}};            // Byte in every lane
                byte_en_o    = byte_en_t'(1) << addr[1:0];       // One-hot lane
            end
            SH: begin
                store_data_o = {(BE_W/2){iss.op_c[15:0]}};       // Half in both halves
                byte_en_o    = byte_en_t'(2'b11) << {addr[1], 1'b0};
            end
            SW: begin
                store_data_o = iss.op_c;
                byte_en_o    = '1;
            end
            default: ;
        endcase
    end

    // Misaligned accesses are not handled by this stage
    always_comb begin
        assert final (!(is_half && addr[0]) && !(is_word && (addr[1:0] != 2'b00)))
            else $error("load_store_unit: misaligned %s at %h", iss.op.name(), addr);
    end

endmodule

/* rv_data_pkg.sv */
/* Datapath widths and vector types of the RV32I execute stage.
 * Import with rv_data_pkg::* wherever a word, tag or byte enable is carried.
 */
package rv_data_pkg;

    localparam int unsigned XLEN    = 32;            // Datapath word width
    localparam int unsigned TAG_W   = 4;             // Instruction tag width
    localparam int unsigned SHAMT_W = $clog2(XLEN);  // Shift amount bits
    localparam int unsigned BE_W    = XLEN / 8;      // One enable per byte lane

    // One datapath word
    typedef logic [XLEN-1:0]    word_t;

    // In-flight instruction tag
    typedef logic [TAG_W-1:0]   tag_t;

    // Shift amount, low bits of operand B
    typedef logic [SHAMT_W-1:0] shamt_t;

    // Byte-lane write enables, bit 0 is the lowest address
    typedef logic [BE_W-1:0]    byte_en_t;

endpackage

/* rv_isa_pkg.sv */
/* RV32I operation codes and execution-unit selectors, shared by the execute
 * stage and its testbench. Import with rv_isa_pkg::* in the module header.
 */
package rv_isa_pkg;

    localparam int unsigned OP_W    = 5;   // Enough for 28 operation codes
    localparam int unsigned XU_W    = 3;   // Six execution-unit selectors
    localparam int unsigned PC_STEP = 4;   // Bytes per instruction, for the link

    // Operation code from decode
    typedef enum logic [OP_W-1:0] {
        NOP,                                    // What a non-selected unit sees
        ADD, SUB, SLT, SLTU,                    // Adder group
        AND, OR, XOR,                           // Logic group
        SLL, SRL, SRA,                          // Shifter group
        LUI,                                    // Goes down the bypass
        BEQ, BNE, BLT, BGE, BLTU, BGEU,         // Conditional branches
        JAL, JALR,                              // Unconditional jumps
        LB, LBU, LH, LHU, LW,                   // Loads
        SB, SH, SW                              // Stores
    } op_t;

    // Execution-unit selector from decode
    typedef enum logic [XU_W-1:0] {
        XU_ADDER,
        XU_LOGIC,
        XU_SHIFT,
        XU_BRANCH,
        XU_MEMORY,
        XU_BYPASS
    } xu_t;

    // True for any operation that may redirect the PC
    function automatic logic is_flow_op(input op_t op);
        return op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR};
    endfunction

endpackage

/* tb_execute.sv */
/* Self-checking testbench for the execute stage. Applies a table of directed
 * rows, then seeded random rows predicted by a reference model.
 */
`timescale 1ns/100ps

module tb_execute
    import rv_isa_pkg::*, rv_data_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;    // Input skew after the rising edge
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 40;

    localparam op_t ALU_OPS [10] = '{ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA};
    localparam op_t BR_OPS  [8]  = '{BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR};
    localparam op_t MEM_OPS [8]  = '{LB, LBU, LH, LHU, LW, SB, SH, SW};

    // One stimulus row and its expected results
    typedef struct packed {
        word_t    pc;
        word_t    a;
        word_t    b;
        word_t    c;
        op_t      op;
        xu_t      xu;
        tag_t     tag;
        word_t    exp_r0;
        word_t    exp_r1;
        logic     exp_jump;
        logic     exp_we;
        logic     exp_ls;
        byte_en_t exp_be;
        logic     exp_rd;      // Same-cycle read strobe
        word_t    exp_raddr;
    } row_t;

    logic        clk;
    logic        arst_n_i;
    word_t       pc_i;
    word_t       op_a_i;
    word_t       op_b_i;
    word_t       op_c_i;
    op_t         op_i;
    xu_t         xu_sel_i;
    tag_t        tag_i;
    word_t       result0_o;
    word_t       result1_o;
    logic        jump_o;
    logic        we_rf_o;
    logic        ls_op_o;
    logic        read_o;
    word_t       read_addr_o;
    byte_en_t    we_mem_o;
    tag_t        tag_o;
    op_t         op_o;

    row_t        rows[$];        // Directed rows first, then random ones
    int          errors = 0;
    int unsigned cycles = 0;
    integer      seed;

    execute uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Watchdog, sized from reset plus one cycle per row
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > RESET_CYCLES + rows.size() + 20) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h @ %0t", name, got, want, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h @ %0t", name, got, want, $time);
        end
    endtask

    task automatic check_byte_en(input string name, input byte_en_t got, input byte_en_t want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h @ %0t", name, got, want, $time);
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h @ %0t", name, got, want, $time);
        end
    endtask

    task automatic check_op(input string name, input op_t got, input op_t want);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s: got %h (%s) expected %h (%s) @ %0t",
                     name, got, got.name(), want, want.name(), $time);
        end
    endtask

    // Registered outputs, one cycle after the row was driven
    task automatic check_registered(input row_t r);
        check_word("result0_o", result0_o, r.exp_r0);
        check_word("result1_o", result1_o, r.exp_r1);
        check_bit("jump_o", jump_o, r.exp_jump);
        check_bit("we_rf_o", we_rf_o, r.exp_we);
        check_bit("ls_op_o", ls_op_o, r.exp_ls);
        check_byte_en("we_mem_o", we_mem_o, r.exp_be);
        check_tag("tag_o", tag_o, r.tag);      // Inputs of the previous cycle
        check_op("op_o", op_o, r.op);
    endtask

    task automatic drive_row(input row_t r);
        pc_i     = r.pc;
        op_a_i   = r.a;
        op_b_i   = r.b;
        op_c_i   = r.c;
        op_i     = r.op;
        xu_sel_i = r.xu;
        tag_i    = r.tag;
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    // Flags column is {jump, we_rf, ls_op, read}
    task automatic add_row(input word_t pc, input word_t a, input word_t b, input word_t c,
                           input op_t op, input xu_t xu, input tag_t tag, input word_t r0,
                           input word_t r1, input logic [3:0] flags, input byte_en_t be,
                           input word_t raddr);
        row_t r;
        r = '{pc, a, b, c, op, xu, tag, r0, r1, flags[3], flags[2], flags[1], be,
              flags[0], raddr};
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row('h0, 'h5, 'h3, 'h0, ADD, XU_ADDER, 4'h1, 'h8, 'h0, 4'b0100, 4'h0, 'h0);
        add_row('h0, 'h5, 'h7, 'h0, SUB, XU_ADDER, 4'h2, -'h2, 'h0, 4'b0100, 4'h0, 'h0);
        add_row('h0, -'h1, 'h1, 'h0, SLT, XU_ADDER, 4'h3, 'h1, 'h0, 4'b0100, 4'h0, 'h0);
        add_row('h0, -'h1, 'h1, 'h0, SLTU, XU_ADDER, 4'h4, 'h0, 'h0, 4'b0100, 4'h0, 'h0);
        add_row('h0, 'hf0f0, 'hff00, 'h0, XOR, XU_LOGIC, 4'h5, 'hff0, 'h0, 4'b0100, 4'h0, 'h0);
        add_row('h0, 'h1, 'h24, 'h0, SLL, XU_SHIFT, 4'h6, 'h10, 'h0, 4'b0100, 4'h0, 'h0);
        add_row('h0, -'h10, 'h4, 'h0, SRL, XU_SHIFT, 4'h7, 'hfffffff, 'h0, 4'b0100, 4'h0, 'h0);
        add_row('h0, -'h10, 'h4, 'h0, SRA, XU_SHIFT, 4'h8, -'h1, 'h0, 4'b0100, 4'h0, 'h0);
        add_row('h1000, 'h5, 'h5, 'h20, BEQ, XU_BRANCH, 4'h9, 'h0, 'h1020, 4'b1000, 4'h0, 'h0);
        add_row('h1000, 'h5, 'h5, 'h20, BNE, XU_BRANCH, 4'ha, 'h0, 'h1020, 4'b0000, 4'h0, 'h0);
        add_row('h1000, -'h1, 'h1, -'h8, BLT, XU_BRANCH, 4'hb, 'h0, 'hff8, 4'b1000, 4'h0, 'h0);
        add_row('h1000, -'h1, 'h1, 'h40, BGEU, XU_BRANCH, 4'hc, 'h0, 'h1040, 4'b1000, 4'h0, 'h0);
        add_row('h1000, -'h1, 'h1, 'h40, BLTU, XU_BRANCH, 4'hd, 'h0, 'h1040, 4'b0000, 4'h0, 'h0);
        add_row('h1000, 'h0, 'h0, 'h100, JAL, XU_BRANCH, 4'he, 'h1004, 'h1100, 4'b1100, 4'h0, 'h0);
        add_row('h1000, 'h2003, 'h0, 'h10, JALR, XU_BRANCH, 4'hf, 'h1004, 'h2012, 4'b1100,
                4'h0, 'h0);                                         // Bit 0 of target dropped
        add_row('h0, 'h400, 'h0, 'h11223344, SB, XU_MEMORY, 4'h0,
                'h44444444, 'h400, 4'b0010, 4'h1, 'h0);
        add_row('h0, 'h400, 'h1, 'h11223344, SB, XU_MEMORY, 4'h1,
                'h44444444, 'h401, 4'b0010, 4'h2, 'h0);
        add_row('h0, 'h400, 'h2, 'h11223344, SB, XU_MEMORY, 4'h2,
                'h44444444, 'h402, 4'b0010, 4'h4, 'h0);
        add_row('h0, 'h400, 'h3, 'h11223344, SB, XU_MEMORY, 4'h3,
                'h44444444, 'h403, 4'b0010, 4'h8, 'h0);
        add_row('h0, 'h400, 'h0, 'h11223344, SH, XU_MEMORY, 4'h4,
                'h33443344, 'h400, 4'b0010, 4'h3, 'h0);
        add_row('h0, 'h400, 'h2, 'h11223344, SH, XU_MEMORY, 4'h5,
                'h33443344, 'h402, 4'b0010, 4'hc, 'h0);             // Upper half
        add_row('h0, 'h400, 'h0, 'h11223344, SW, XU_MEMORY, 4'h6,
                'h11223344, 'h400, 4'b0010, 4'hf, 'h0);
        add_row('h0, 'h800, 'h8, 'h0, LW, XU_MEMORY, 4'h7, 'h0, 'h808, 4'b0111, 4'h0, 'h808);
        add_row('h0, 'h800, 'h7, 'h0, LB, XU_MEMORY, 4'h8, 'h0, 'h807, 4'b0111, 4'h0, 'h804);
        add_row('h0, 'h800, 'h6, 'h0, LHU, XU_MEMORY, 4'h9, 'h0, 'h806, 4'b0111, 4'h0, 'h804);
        add_row('h0, 'h0, 'habcde000, 'h0, LUI, XU_BYPASS, 4'ha, 'habcde000, 'h0, 4'b0100,
                4'h0, 'h0);
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic row_t predict(input row_t r);
        word_t ea;
        ea          = r.a + r.b;     // Memory effective address
        r.exp_r0    = '0;
        r.exp_r1    = '0;
        r.exp_jump  = 1'b0;
        r.exp_we    = 1'b1;
        r.exp_ls    = 1'b0;
        r.exp_be    = '0;
        r.exp_rd    = 1'b0;
        r.exp_raddr = '0;
        case (r.xu)
            XU_ADDER, XU_LOGIC, XU_SHIFT: begin
                case (r.op)
                    ADD:     r.exp_r0 = r.a + r.b;
                    SUB:     r.exp_r0 = r.a - r.b;
                    SLT:     r.exp_r0 = word_t'($signed(r.a) < $signed(r.b));
                    SLTU:    r.exp_r0 = word_t'(r.a < r.b);
                    AND:     r.exp_r0 = r.a & r.b;
                    OR:      r.exp_r0 = r.a | r.b;
                    XOR:     r.exp_r0 = r.a ^ r.b;
                    SLL:     r.exp_r0 = r.a << r.b[4:0];
                    SRL:     r.exp_r0 = r.a >> r.b[4:0];
                    SRA:     r.exp_r0 = word_t'($signed(r.a) >>> r.b[4:0]);
                    default: r.exp_r0 = '0;
                endcase
            end
            XU_BRANCH: begin
                r.exp_we = 1'b0;
                r.exp_r1 = r.pc + r.c;
                case (r.op)
                    BEQ:     r.exp_jump = (r.a == r.b);
                    BNE:     r.exp_jump = (r.a != r.b);
                    BLT:     r.exp_jump = ($signed(r.a) < $signed(r.b));
                    BGE:     r.exp_jump = ($signed(r.a) >= $signed(r.b));
                    BLTU:    r.exp_jump = (r.a < r.b);
                    BGEU:    r.exp_jump = (r.a >= r.b);
                    default: begin                         // JAL and JALR
                        r.exp_jump = 1'b1;
                        r.exp_we   = 1'b1;
                        r.exp_r0   = r.pc + 32'd4;
                        if (r.op == JALR) begin
                            r.exp_r1 = (r.a + r.c) & ~32'h1;
                        end
                    end
                endcase
            end
            XU_MEMORY: begin
                r.exp_ls = 1'b1;
                r.exp_r1 = ea;
                r.exp_we = 1'b0;
                case (r.op)
                    SB: begin
                        r.exp_r0 = {4{r.c[7:0]}};
                        r.exp_be = 4'b0001 << ea[1:0];
                    end
                    SH: begin
                        r.exp_r0 = {2{r.c[15:0]}};
                        r.exp_be = ea[1] ? 4'b1100 : 4'b0011;
                    end
                    SW: begin
                        r.exp_r0 = r.c;
                        r.exp_be = 4'b1111;
                    end
                    default: begin                         // Loads
                        r.exp_we    = 1'b1;
                        r.exp_rd    = 1'b1;
                        r.exp_raddr = ea & ~32'h3;
                    end
                endcase
            end
            default: r.exp_r0 = r.b;                       // Bypass
        endcase
        return r;
    endfunction

    task automatic add_random_rows(input int count);
        row_t r;
        int   k;
        int   pick;
        for (k = 0; k < count; k++) begin
            r      = '0;
            r.pc   = $random(seed) & ~32'h3;
            r.a    = $random(seed);
            r.b    = $random(seed);
            r.c    = $random(seed);
            r.tag  = tag_t'($random(seed));
            pick   = $unsigned($random(seed)) % 6;
            r.xu   = xu_t'(pick);
            pick   = $unsigned($random(seed)) % 8;
            case (r.xu)
                XU_ADDER, XU_LOGIC, XU_SHIFT: r.op = ALU_OPS[$unsigned($random(seed)) % 10];
                XU_BRANCH: r.op = BR_OPS[pick];
                XU_MEMORY: begin
                    r.op      = MEM_OPS[pick];
                    r.a[1:0]  = 2'b00;                     // Keep accesses aligned
                    if (r.op inside {LH, LHU, SH}) begin
                        r.b[0] = 1'b0;
                    end
                    if (r.op inside {LW, SW}) begin
                        r.b[1:0] = 2'b00;
                    end
                end
                default: r.op = LUI;
            endcase
            rows.push_back(predict(r));
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        row_t idle;
        int   n;
        seed     = 97;
        idle     = '0;                 // Reset values, op NOP, tag 0
        arst_n_i = 1'b0;
        drive_row(idle);
        build_table();
        add_random_rows(N_RANDOM);
        n = rows.size();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        check_registered(idle);        // Still in reset, nothing driven yet
        check_bit("read_o", read_o, 1'b0);
        arst_n_i = 1'b1;
        for (int i = 0; i <= n; i++) begin
            if (i > 0) begin
                @(posedge clk);
                #DRIVE_DLY;
                check_registered(rows[i-1]);
            end
            if (i < n) begin
                drive_row(rows[i]);
                #(CLK_PERIOD/4);       // Read request is combinational
                check_bit("read_o", read_o, rows[i].exp_rd);
                check_word("read_addr_o", read_addr_o, rows[i].exp_raddr);
            end
        end
        $display("Finished %0d rows with %0d errors", n, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* xu_issue_if.sv */
/* Issue bundle from the execute dispatcher to one execution unit.
 * The dispatcher drives operands, PC and the gated operation; the unit reads.
 */
`timescale 1ns/100ps

interface xu_issue_if
    import rv_isa_pkg::*, rv_data_pkg::*;
();

    word_t op_a;   // Register operand A
    word_t op_b;   // Register operand B or immediate
    word_t op_c;   // Offset or store data
    word_t pc;     // PC of this instruction
    op_t   op;     // NOP unless this unit is selected

    modport dispatcher (output op_a, op_b, op_c, pc, op);
    modport unit       (input  op_a, op_b, op_c, pc, op);

endinterface
